// File: common/pf_pkg.sv
// fetch prefetch package
// shared types, line geometry, controller states and the prefetch request
`default_nettype none

package pf_pkg;

    // byte address of an instruction line
    typedef logic [31:0] addr_t;
    // one cache line, 32 bytes
    typedef logic [255:0] line_t;
    // selects one of the buffer entries
    typedef logic entry_idx_t;

    // line size in bytes, also the next-line step
    localparam int unsigned LINE_BYTES = 32;
    localparam int unsigned NUM_ENTRIES = 2;
    // low bits set so it never equals an aligned request
    localparam addr_t INVALID_ADDR = 32'h0000_000f;

    typedef enum logic [1:0] {
        IDLE,
        DEMAND_PMEM,
        DEMAND_BUF,
        PREFETCH
    } fetch_state_e;

    // pending next-line target from the prefetcher
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } pf_req_t;

endpackage

`default_nettype wire

// File: hw/prefetch_buffer.sv
// prefetch buffer
// two fully associative line entries with one victim bit
// lookup is combinational, fills land in the victim entry
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer import pf_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t lookup_addr,
    input  wire logic  demand_read,
    input  wire logic  pf_write,
    input  wire logic  pf_ld,
    input  wire line_t fill_line,
    output logic       buf_hit,
    output logic       buf_resp,
    output line_t      buf_line
);

    // stored tags and data
    addr_t entry_addr [NUM_ENTRIES];
    line_t entry_line [NUM_ENTRIES];

    // next entry to be overwritten
    entry_idx_t victim;
    entry_idx_t hit_idx;
    logic [NUM_ENTRIES-1:0] match;
    logic fill_en;

    // tag compare on every entry
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            match[i] = (lookup_addr == entry_addr[i]);
        end
    end

    // lowest matching entry wins, only one can match in practice
    always_comb begin
        buf_hit = 1'b0;
        hit_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                buf_hit = 1'b1;
                hit_idx = entry_idx_t'(i);
            end
        end
    end

    assign buf_line = entry_line[hit_idx];
    // hit answers at once, a miss answers with the fill
    assign buf_resp = buf_hit | pf_ld;

    // prefetch miss with returning pmem data
    assign fill_en = pf_write & pf_ld & ~buf_hit;

    // tags and victim bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            victim <= '0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entry_addr[i] <= INVALID_ADDR;
            end
        end else begin
            if (fill_en) begin
                entry_addr[victim] <= lookup_addr;
                // alternate after each fill
                victim <= ~victim;
            end else if (buf_hit && (demand_read || pf_write)) begin
                // keep the entry just used
                victim <= ~hit_idx;
            end
        end
    end

    // line data, written alongside its tag
    always_ff @(posedge clk) begin
        if (fill_en) begin
            entry_line[victim] <= fill_line;
        end
    end

endmodule

`default_nettype wire

// File: hw/next_line_prefetcher.sv
// next-line prefetcher
// after each demand the following line becomes the pending target,
// held until the controller takes it or a newer demand replaces it
`timescale 1ns/1ps
`default_nettype none

module next_line_prefetcher import pf_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  demand_done,
    input  wire addr_t demand_addr,
    input  wire logic  pf_taken,
    output pf_req_t    pf_req
);

    logic  target_valid;
    addr_t target_addr;
    addr_t line_base;
    addr_t next_line;

    // align the demand down to its line first
    assign line_base = demand_addr & ~addr_t'(LINE_BYTES - 1);
    // one line further on
    assign next_line = line_base + addr_t'(LINE_BYTES);

    // pending flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            target_valid <= 1'b0;
        end else begin
            if (demand_done) begin
                // newer demand always wins, an unstarted target is dropped
                target_valid <= 1'b1;
            end else if (pf_taken) begin
                target_valid <= 1'b0;
            end
        end
    end

    // target address
    always_ff @(posedge clk) begin
        if (demand_done) begin
            target_addr <= next_line;
        end
    end

    always_comb begin
        pf_req.valid = target_valid;
        pf_req.addr  = target_addr;
    end

endmodule

`default_nettype wire

// File: hw/fetch_controller.sv
// fetch controller
// serves imem from the prefetch buffer or from pmem, runs prefetches
// when the fetch side is idle, owns the pmem port
`timescale 1ns/1ps
`default_nettype none

module fetch_controller import pf_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    imem_read,
    input  wire addr_t   imem_addr,
    output logic         imem_resp,
    output line_t        imem_rdata,
    output logic         imem_from_pf,
    output logic         pmem_read,
    output addr_t        pmem_addr,
    input  wire logic    pmem_resp,
    input  wire line_t   pmem_rdata,
    input  wire pf_req_t pf_req,
    output logic         pf_taken,
    output logic         demand_done,
    output addr_t        demand_addr,
    output addr_t        lookup_addr,
    output logic         demand_read,
    output logic         pf_write,
    output logic         pf_ld,
    input  wire logic    buf_hit,
    input  wire line_t   buf_line,
    input  wire logic    buf_resp
);

    fetch_state_e state;
    fetch_state_e state_next;

    // address held on the pmem port for the whole request
    addr_t req_addr_q;
    // address of the demand in flight
    addr_t demand_addr_q;

    logic demand_req;
    logic demand_hit;
    logic demand_miss;
    logic pf_start;
    logic pmem_done;

    // imem_read is still high in the response cycle, do not take it again
    assign demand_req  = imem_read & ~imem_resp;
    assign demand_read = (state == IDLE) & demand_req;
    assign demand_hit  = demand_read & buf_hit;
    assign demand_miss = demand_read & ~buf_hit;

    // prefetch only when imem is quiet
    assign pf_start = (state == IDLE) & ~imem_read & pf_req.valid;
    assign pf_taken = pf_start;

    assign pf_write = (state == PREFETCH);
    assign pf_ld    = pf_write & pmem_resp;

    // a prefetch that hits never touches pmem
    assign pmem_read = (state == DEMAND_PMEM) | (pf_write & ~buf_hit);
    assign pmem_addr = req_addr_q;
    assign pmem_done = (state == DEMAND_PMEM) & pmem_resp;

    // completion goes to the prefetcher with the response
    assign demand_done = imem_resp;
    assign demand_addr = demand_addr_q;

    // buffer lookup steering
    always_comb begin
        if (state == IDLE && imem_read) begin
            lookup_addr = imem_addr;
        end else if (state == PREFETCH) begin
            lookup_addr = req_addr_q;
        end else begin
            lookup_addr = pf_req.addr;
        end
    end

    // next state, demands before prefetches
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (demand_hit) begin
                    state_next = DEMAND_BUF;
                end else if (demand_miss) begin
                    state_next = DEMAND_PMEM;
                end else if (pf_start) begin
                    state_next = PREFETCH;
                end
            end
            DEMAND_PMEM: begin
                if (pmem_resp) begin
                    state_next = IDLE;
                end
            end
            // response cycle of a buffer hit
            DEMAND_BUF: state_next = IDLE;
            // hit or fill both end the prefetch
            PREFETCH: begin
                if (buf_resp) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // state and response flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            imem_resp    <= 1'b0;
            imem_from_pf <= 1'b0;
        end else begin
            state     <= state_next;
            imem_resp <= 1'b0;
            if (demand_hit) begin
                imem_resp    <= 1'b1;
                imem_from_pf <= 1'b1;
            end else if (pmem_done) begin
                imem_resp    <= 1'b1;
                imem_from_pf <= 1'b0;
            end
        end
    end

    // addresses and response data
    always_ff @(posedge clk) begin
        if (demand_read) begin
            demand_addr_q <= imem_addr;
            req_addr_q    <= imem_addr;
        end else if (pf_start) begin
            req_addr_q <= pf_req.addr;
        end
        if (demand_hit) begin
            imem_rdata <= buf_line;
        end else if (pmem_done) begin
            imem_rdata <= pmem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
// fetch front end top
// prefetch buffer, next-line prefetcher and fetch controller
// between the imem and pmem ports
`timescale 1ns/1ps
`default_nettype none

module fetch_top import pf_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    // imem side
    input  wire logic  imem_read,
    input  wire addr_t imem_addr,
    output logic       imem_resp,
    output line_t      imem_rdata,
    output logic       imem_from_pf,
    // pmem side
    output logic       pmem_read,
    output addr_t      pmem_addr,
    input  wire logic  pmem_resp,
    input  wire line_t pmem_rdata
);

    // controller to buffer
    addr_t lookup_addr;
    logic  demand_read;
    logic  pf_write;
    logic  pf_ld;
    // buffer to controller
    logic  buf_hit;
    logic  buf_resp;
    line_t buf_line;
    // controller and prefetcher
    logic    demand_done;
    addr_t   demand_addr;
    logic    pf_taken;
    pf_req_t pf_req;

    prefetch_buffer u_buffer (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .demand_read (demand_read),
        .pf_write    (pf_write),
        .pf_ld       (pf_ld),
        // fills always come straight from pmem
        .fill_line   (pmem_rdata),
        .buf_hit     (buf_hit),
        .buf_resp    (buf_resp),
        .buf_line    (buf_line)
    );

    next_line_prefetcher u_prefetcher (
        .clk         (clk),
        .rst         (rst),
        .demand_done (demand_done),
        .demand_addr (demand_addr),
        .pf_taken    (pf_taken),
        .pf_req      (pf_req)
    );

    fetch_controller u_controller (
        .clk          (clk),
        .rst          (rst),
        .imem_read    (imem_read),
        .imem_addr    (imem_addr),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .imem_from_pf (imem_from_pf),
        .pmem_read    (pmem_read),
        .pmem_addr    (pmem_addr),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata),
        .pf_req       (pf_req),
        .pf_taken     (pf_taken),
        .demand_done  (demand_done),
        .demand_addr  (demand_addr),
        .lookup_addr  (lookup_addr),
        .demand_read  (demand_read),
        .pf_write     (pf_write),
        .pf_ld        (pf_ld),
        .buf_hit      (buf_hit),
        .buf_line     (buf_line),
        .buf_resp     (buf_resp)
    );

endmodule

`default_nettype wire

// File: verif/fetch_properties.sv
// fetch controller assertions
// response pulse, pmem hold, fill qualification, no pmem on a buffer hit
`timescale 1ns/1ps
`default_nettype none

module fetch_properties import pf_pkg::*; (
    input wire logic  clk,
    input wire logic  rst,
    input wire logic  imem_resp,
    input wire logic  pmem_read,
    input wire addr_t pmem_addr,
    input wire logic  pmem_resp,
    input wire logic  pf_write,
    input wire logic  pf_ld,
    input wire logic  demand_read,
    input wire logic  buf_hit
);

    // single cycle response
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        imem_resp |=> !imem_resp)
        else $error("imem_resp high for more than one cycle");

    // request held with a fixed address until pmem answers
    pmem_hold: assert property (@(posedge clk) disable iff (rst)
        (pmem_read && !pmem_resp) |=> (pmem_read && $stable(pmem_addr)))
        else $error("pmem request dropped or address changed before pmem_resp");

    // fills only answer a prefetch that missed and went to pmem
    fill_in_prefetch: assert property (@(posedge clk) disable iff (rst)
        pf_ld |-> (pf_write && pmem_read))
        else $error("pf_ld outside a prefetch pmem read");

    // buffer hit is served without pmem, in the lookup and response cycles
    hit_no_pmem: assert property (@(posedge clk) disable iff (rst)
        (demand_read && buf_hit) |-> !pmem_read)
        else $error("pmem_read during a demand buffer hit");

    hit_no_pmem_next: assert property (@(posedge clk) disable iff (rst)
        (demand_read && buf_hit) |=> !pmem_read)
        else $error("pmem_read in the cycle after a demand buffer hit");

endmodule

`default_nettype wire

// File: verif/fetch_tb.sv
// fetch front end testbench
// requests come from the input file, pmem answers with random latency,
// a reference buffer model predicts hits and the pmem address trace
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import pf_pkg::*; ();

    localparam int MAX_REQ = 32;
    localparam int RESP_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 200;

    logic  clk;
    logic  rst;
    logic  imem_read;
    addr_t imem_addr;
    logic  imem_resp;
    line_t imem_rdata;
    logic  imem_from_pf;
    logic  pmem_read;
    addr_t pmem_addr;
    logic  pmem_resp;
    line_t pmem_rdata;

    // three words per request: address, gap, hit flag
    logic [31:0] stim_mem [3*MAX_REQ];

    // reference buffer tags and victim
    addr_t      ref_addr [NUM_ENTRIES];
    entry_idx_t ref_victim;

    // pmem reads predicted by the model and seen on the port
    addr_t exp_pmem [$];
    addr_t seen_pmem [$];

    logic [31:0] rng_state = 32'hbc79_775a;
    int error_count;
    int check_count;

    fetch_top u_fetch_top (
        .clk          (clk),
        .rst          (rst),
        .imem_read    (imem_read),
        .imem_addr    (imem_addr),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .imem_from_pf (imem_from_pf),
        .pmem_read    (pmem_read),
        .pmem_addr    (pmem_addr),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata)
    );

    bind fetch_controller fetch_properties u_properties (
        .clk         (clk),
        .rst         (rst),
        .imem_resp   (imem_resp),
        .pmem_read   (pmem_read),
        .pmem_addr   (pmem_addr),
        .pmem_resp   (pmem_resp),
        .pf_write    (pf_write),
        .pf_ld       (pf_ld),
        .demand_read (demand_read),
        .buf_hit     (buf_hit)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // line address in every word, xored with the word index
    function automatic line_t make_line(addr_t a);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = a ^ 32'(w);
        end
        return l;
    endfunction

    // matching entry or -1
    function automatic int ref_lookup(addr_t a);
        int idx;
        idx = -1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ref_addr[i] == a) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // demand: a hit points the victim away, a miss goes to pmem only
    function automatic logic model_demand(addr_t a);
        int idx;
        idx = ref_lookup(a);
        if (idx >= 0) begin
            ref_victim = (idx == 0);
            return 1'b1;
        end
        exp_pmem.push_back(a);
        return 1'b0;
    endfunction

    // prefetch: hit only moves the victim, miss fills it and flips
    task automatic model_prefetch(addr_t a);
        int idx;
        idx = ref_lookup(a);
        if (idx >= 0) begin
            ref_victim = (idx == 0);
        end else begin
            exp_pmem.push_back(a);
            ref_addr[ref_victim] = a;
            ref_victim = ~ref_victim;
        end
    endtask

    task automatic compare_line(string name, line_t got, line_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_hit(string name, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, got);
        end
    endtask

    task automatic compare_addr(string name, addr_t got, addr_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    // pair up predicted and observed pmem reads
    task automatic check_pmem_trace();
        while (exp_pmem.size() > 0 && seen_pmem.size() > 0) begin
            compare_addr("pmem_addr", seen_pmem.pop_front(), exp_pmem.pop_front());
        end
        if (exp_pmem.size() != seen_pmem.size()) begin
            error_count++;
            $display("pmem read count differs from the model: %0d expected and %0d seen left over",
                exp_pmem.size(), seen_pmem.size());
            exp_pmem.delete();
            seen_pmem.delete();
        end
    endtask

    // sampled on the falling edge, away from the DUT updates
    task automatic wait_response(output logic got);
        int n;
        got = 1'b0;
        n = 0;
        while (!got && n < RESP_TIMEOUT) begin
            @(negedge clk);
            got = imem_resp;
            n++;
        end
    endtask

    // pmem with 1 to 6 cycles of latency
    initial begin : pmem_model
        int    lat;
        addr_t rd_addr;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && pmem_read) begin
                rd_addr = pmem_addr;
                seen_pmem.push_back(rd_addr);
                lat = 1 + int'(next_rand() % 32'd6);
                repeat (lat) @(posedge clk);
                pmem_resp  <= 1'b1;
                pmem_rdata <= make_line(rd_addr);
                @(posedge clk);
                pmem_resp <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        int    n_req;
        int    gap;
        int    errors_before;
        int    wait_n;
        addr_t addr;
        logic  exp_hit;
        logic  model_hit;
        logic  got_resp;
        logic  timed_out;

        clk = 1'b0;
        rst = 1'b1;
        imem_read = 1'b0;
        imem_addr = '0;
        error_count = 0;
        check_count = 0;
        timed_out = 1'b0;
        ref_victim = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ref_addr[i] = INVALID_ADDR;
        end
        // unused rows keep an unaligned address, which ends the row count
        for (int i = 0; i < 3*MAX_REQ; i++) begin
            stim_mem[i] = 32'h0000_00ff | (32'(i) << 8);
        end
        $readmemh("verif/fetch_input.txt", stim_mem);
        n_req = 0;
        while (n_req < MAX_REQ && stim_mem[3*n_req][4:0] == 5'd0) begin
            n_req++;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_req && !timed_out; i++) begin
            addr = stim_mem[3*i];
            gap = int'(stim_mem[3*i+1]);
            exp_hit = stim_mem[3*i+2][0];
            errors_before = error_count;
            model_hit = model_demand(addr);
            if (model_hit !== exp_hit) begin
                error_count++;
                $display("reference model and input file disagree on the hit of request %0d", i);
            end
            @(posedge clk);
            imem_read <= 1'b1;
            imem_addr <= addr;
            wait_response(got_resp);
            if (!got_resp) begin
                timed_out = 1'b1;
                error_count++;
                $display("no imem_resp for request %0d at address %h", i, addr);
            end else begin
                compare_line("imem_rdata", imem_rdata, make_line(addr));
                compare_hit("imem_from_pf", imem_from_pf, exp_hit);
                check_pmem_trace();
                $display("request %0d addr %h gap %0d hit %b %s", i, addr, gap, exp_hit,
                    (error_count == errors_before) ? "passed" : "failed");
                // idle cycles let the next-line prefetch run
                if (gap > 0 || i == n_req - 1) begin
                    model_prefetch(addr + addr_t'(LINE_BYTES));
                end
                if (gap > 0) begin
                    @(posedge clk);
                    imem_read <= 1'b0;
                    repeat (gap - 1) @(posedge clk);
                end
            end
        end

        @(posedge clk);
        imem_read <= 1'b0;

        // let the last prefetch finish
        if (!timed_out) begin
            wait_n = 0;
            while ((wait_n < 8 || seen_pmem.size() < exp_pmem.size() || pmem_read)
                   && wait_n < DRAIN_TIMEOUT) begin
                @(negedge clk);
                wait_n++;
            end
            if (seen_pmem.size() < exp_pmem.size() || pmem_read) begin
                timed_out = 1'b1;
                error_count++;
                $display("pmem still busy long after the last request");
            end else begin
                errors_before = error_count;
                check_pmem_trace();
                $display("final prefetch trace %s",
                    (error_count == errors_before) ? "passed" : "failed");
            end
        end

        $display("requests %0d checks %0d errors %0d", n_req, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fetch_input.txt
// columns: line address, idle gap in cycles, expected buffer hit (1 = served from buffer)
// all values hex, one request per line
00001000 1 0
00001020 1 1
00001040 2 1
00001060 0 1
00001080 1 0
000010a0 1 1
000010a0 1 1
000010c0 0 1
000010a0 1 1
000010c0 0 1
00002000 1 0
000010c0 0 1
000010a0 1 0
00002020 2 1
00002040 1 1
00002060 3 1
00002080 0 1
000020a0 1 0
00001000 1 0
000020c0 2 1
00001020 1 0
00001040 1 1

// File: list.f
common/pf_pkg.sv
hw/prefetch_buffer.sv
hw/next_line_prefetcher.sv
hw/fetch_controller.sv
hw/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fetch_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

CHECK_LOG = if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

.PHONY: all run check clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@$(CHECK_LOG)

check:
	@$(CHECK_LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
